// File: list.f
+incdir+source
source/pixel_pkg.sv
source/bus_decoder.sv
source/gpio_regs.sv
source/word_fifo.sv
source/sr_capture.sv
source/hit_timer.sv
source/rr_arbiter.sv
source/pixel_top.sv
verif/pixel_sva.sv
verif/pixel_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the pixel readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module pixel_tb -Mdir obj_dir; then
    echo "verilator compile failed"
    exit 1
fi

if ! out=$(./obj_dir/Vpixel_tb); then
    printf '%s\n' "$out"
    echo "simulation returned an error status"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: verif/pixel_tb.sv
// testbench for the pixel readout core with a queue model of the output stream
`default_nettype none
`include "pixel_consts.svh"

module pixel_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pixel_pkg::*;

    // all tests together take well under 1000 cycles
    localparam int MAX_CYCLES = 4000;

    logic       bus_clk;
    logic       arst_n;
    bus_addr_t  add;
    logic [7:0] bus_wr_data;
    logic       bus_rd;
    logic       bus_wr;
    logic       sdi;
    logic       sen;
    logic       hit_or;
    logic       out_read;
    logic [7:0] bus_rd_data;
    logic [7:0] gpio_out;
    logic       out_valid;
    word_t      out_data;

    // expected words per source in push order
    word_t       sr_q[$];
    word_t       hit_q[$];
    logic [3:0]  taken_ids[$];
    logic [15:0] last_stamp = 16'h0000;
    logic [31:0] rng_state = 32'hb46f_2976;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_num = 0;
    int          test_errors = 0;

    pixel_top uut (
        .bus_clk     (bus_clk),
        .arst_n      (arst_n),
        .add         (add),
        .bus_wr_data (bus_wr_data),
        .bus_rd      (bus_rd),
        .bus_wr      (bus_wr),
        .sdi         (sdi),
        .sen         (sen),
        .hit_or      (hit_or),
        .out_read    (out_read),
        .bus_rd_data (bus_rd_data),
        .gpio_out    (gpio_out),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    initial begin
        bus_clk = 1'b0;
        forever #10 bus_clk = ~bus_clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bus_addr_t block_address(input logic [15:0] base, input logic [3:0] idx);
        return `PIX_BUS_OFFSET + base + {12'h000, idx};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // match a taken word against the model queue of its source
    task automatic take_word(input word_t w);
        word_t exp;
        logic  matched;
        taken_ids.push_back(w[31:28]);
        matched = (w[31:28] == `PIX_SR_ID && sr_q.size() > 0) ||
                  (w[31:28] == `PIX_HIT_ID && hit_q.size() > 0);
        checks++;
        assert (matched) else begin
            $display("unexpected output word 0x%h, no such word was expected", w);
            errors++;
        end
        if (matched && w[31:28] == `PIX_SR_ID) begin
            exp = sr_q.pop_front();
            check_val("out_data", w, exp);
        end else if (matched) begin
            exp = hit_q.pop_front();
            // stamp comes from the free-running counter so only its order is known
            check_val("out_data id and width", 32'(w[31:16]), 32'(exp[31:16]));
            checks++;
            assert (w[15:0] > last_stamp) else begin
                $display("[FAIL] out_data stamp: got 0x%h, previous 0x%h", w[15:0], last_stamp);
                errors++;
            end
            last_stamp = w[15:0];
        end
    endtask

    initial begin
        forever begin
            @(posedge bus_clk);
            if (arst_n && out_valid && out_read)
                take_word(out_data);
        end
    end

    initial begin
        forever begin
            @(posedge bus_clk);
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                $display("run stopped at the cycle limit of %0d cycles", MAX_CYCLES);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    task automatic bus_write(input bus_addr_t a, input logic [7:0] d);
        add = a;
        bus_wr_data = d;
        bus_wr = 1'b1;
        @(negedge bus_clk);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t a, output logic [7:0] d);
        add = a;
        bus_rd = 1'b1;
        @(negedge bus_clk);
        bus_rd = 1'b0;
        d = bus_rd_data;
    endtask

    // random bits under sen with one model word per complete group
    task automatic shift_bits(input int count, input bit expect_words);
        logic [31:0]             r;
        logic [`PIX_SR_BITS-1:0] bits;
        int                      n;
        n = 0;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            r = next_random();
            sdi = r[0];
            sen = 1'b1;
            bits = {bits[`PIX_SR_BITS-2:0], r[0]};
            n++;
            @(negedge bus_clk);
            if (n == `PIX_SR_BITS) begin
                if (expect_words)
                    sr_q.push_back({`PIX_SR_ID, bits});
                n = 0;
            end
        end
        sen = 1'b0;
        sdi = 1'b0;
        @(negedge bus_clk);
    endtask

    task automatic hit_pulse(input int width, input bit expect_word);
        hit_or = 1'b1;
        repeat (width) @(negedge bus_clk);
        hit_or = 1'b0;
        if (expect_word)
            hit_q.push_back({`PIX_HIT_ID, 12'(width), 16'h0000});
        // low long enough for sync and edge detect
        repeat (6) @(negedge bus_clk);
    endtask

    task automatic wait_drained();
        while (sr_q.size() > 0 || hit_q.size() > 0)
            @(negedge bus_clk);
        // room for a stray extra word to show up
        repeat (4) @(negedge bus_clk);
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == test_errors)
            $display("test %0d %s: ok", test_num, name);
        else
            $display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  rd;
        logic [7:0]  gp;
        int          dropped;
        arst_n = 1'b0;
        add = '0;
        bus_wr_data = 8'h00;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        sdi = 1'b0;
        sen = 1'b0;
        hit_or = 1'b0;
        out_read = 1'b0;
        repeat (2) @(negedge bus_clk);
        arst_n = 1'b1;
        @(negedge bus_clk);

        check_val("gpio_out", 32'(gpio_out), 32'h0);
        check_val("bus_rd_data", 32'(bus_rd_data), 32'h0);
        check_val("out_valid", 32'(out_valid), 32'h0);
        r = next_random();
        gp = r[7:0];
        bus_write(block_address(`PIX_GPIO_BASE, 4'd0), gp);
        check_val("gpio_out", 32'(gpio_out), 32'(gp));
        bus_read(block_address(`PIX_GPIO_BASE, 4'd0), rd);
        check_val("bus_rd_data", 32'(rd), 32'(gp));
        bus_read(block_address(16'h0300, 4'd2), rd);
        check_val("bus_rd_data", 32'(rd), 32'h0);
        end_test("gpio");

        out_read = 1'b1;
        bus_write(block_address(`PIX_SR_BASE, 4'd0), 8'h01);
        shift_bits(2 * `PIX_SR_BITS + 10, 1'b1);
        wait_drained();
        end_test("serial capture");

        bus_write(block_address(`PIX_HIT_BASE, 4'd0), 8'h01);
        repeat (4) begin
            r = next_random();
            hit_pulse(int'(r[4:0]) + 1, 1'b1);
        end
        wait_drained();
        end_test("hit timer");

        // first serial word sits in the buffer and then the sources alternate
        out_read = 1'b0;
        taken_ids.delete();
        shift_bits(3 * `PIX_SR_BITS, 1'b1);
        repeat (3) begin
            r = next_random();
            hit_pulse(int'(r[4:0]) + 1, 1'b1);
        end
        out_read = 1'b1;
        wait_drained();
        check_val("taken word count", 32'(taken_ids.size()), 32'd6);
        foreach (taken_ids[i])
            check_val("out_data id", 32'(taken_ids[i]),
                      (i % 2 == 0) ? 32'(`PIX_SR_ID) : 32'(`PIX_HIT_ID));
        end_test("round robin");

        bus_read(block_address(`PIX_SR_BASE, 4'd0), rd);
        check_val("sr enable", 32'(rd), 32'h1);
        bus_read(block_address(`PIX_HIT_BASE, 4'd0), rd);
        check_val("hit enable", 32'(rd), 32'h1);
        bus_write(block_address(`PIX_SR_BASE, 4'd0), 8'h00);
        bus_write(block_address(`PIX_HIT_BASE, 4'd0), 8'h00);
        bus_read(block_address(`PIX_SR_BASE, 4'd0), rd);
        check_val("sr enable", 32'(rd), 32'h0);
        bus_read(block_address(`PIX_HIT_BASE, 4'd0), rd);
        check_val("hit enable", 32'(rd), 32'h0);
        // stalled consumer so a stray word would stay in the buffer
        out_read = 1'b0;
        shift_bits(`PIX_SR_BITS, 1'b0);
        hit_pulse(5, 1'b0);
        repeat (10) @(negedge bus_clk);
        check_val("out_valid", 32'(out_valid), 32'h0);
        out_read = 1'b1;
        end_test("disabled sources");

        bus_write(block_address(`PIX_SR_BASE, 4'd0), 8'h01);
        out_read = 1'b0;
        shift_bits(6 * `PIX_SR_BITS, 1'b1);
        // one word in the arbiter buffer and the FIFO full behind it
        dropped = 6 - `PIX_FIFO_DEPTH - 1;
        repeat (dropped) void'(sr_q.pop_back());
        bus_read(block_address(`PIX_SR_BASE, 4'd1), rd);
        check_val("sr overflow", 32'(rd), 32'(dropped));
        out_read = 1'b1;
        wait_drained();
        end_test("overflow");

        $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/pixel_sva.sv
// output stream assertions for the round-robin arbiter
`default_nettype none

module pixel_sva (
    input wire              bus_clk,
    input wire              arst_n,
    input wire              sr_empty,
    input wire              hit_empty,
    input wire              sr_read,
    input wire              hit_read,
    input wire              out_read,
    input wire              out_valid,
    input pixel_pkg::word_t out_data
);
    timeunit 1ns;
    timeprecision 100ps;

    // buffer starts out empty
    reset_empty: assert property (@(posedge bus_clk) $rose(arst_n) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

    // word held while the consumer stalls
    stall_hold: assert property (@(posedge bus_clk) disable iff (!arst_n)
        out_valid && !out_read |=> out_valid && $stable(out_data))
        else $error("out_data changed or out_valid dropped while stalled");

    sr_no_underflow: assert property (@(posedge bus_clk) disable iff (!arst_n)
        sr_read |-> !sr_empty)
        else $error("sr_read asserted on an empty serial queue");

    hit_no_underflow: assert property (@(posedge bus_clk) disable iff (!arst_n)
        hit_read |-> !hit_empty)
        else $error("hit_read asserted on an empty hit queue");

endmodule

bind rr_arbiter pixel_sva u_sva (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .sr_empty  (sr_empty),
    .hit_empty (hit_empty),
    .sr_read   (sr_read),
    .hit_read  (hit_read),
    .out_read  (out_read),
    .out_valid (out_valid),
    .out_data  (out_data)
);

`default_nettype wire

// File: source/pixel_top.sv
// pixel readout core, register bus blocks, data sources and output arbiter
`default_nettype none

module pixel_top (
    input  wire                  bus_clk,
    input  wire                  arst_n,
    input  pixel_pkg::bus_addr_t add,
    input  wire [7:0]            bus_wr_data,
    input  wire                  bus_rd,
    input  wire                  bus_wr,
    input  wire                  sdi,
    input  wire                  sen,
    input  wire                  hit_or,
    input  wire                  out_read,
    output logic [7:0]           bus_rd_data,
    output logic [7:0]           gpio_out,
    output logic                 out_valid,
    output pixel_pkg::word_t     out_data
);
    import pixel_pkg::*;

    reg_addr_t  reg_addr;
    logic       gpio_wr;
    logic       sr_wr;
    logic       hit_wr;
    logic [7:0] gpio_rd_data;
    logic [7:0] sr_rd_data;
    logic [7:0] hit_rd_data;

    logic       sr_empty;
    logic       sr_read;
    word_t      sr_data;
    logic       hit_empty;
    logic       hit_read;
    word_t      hit_data;

    // decode stage
    bus_decoder u_decoder (
        .bus_clk      (bus_clk),
        .arst_n       (arst_n),
        .add          (add),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .gpio_rd_data (gpio_rd_data),
        .sr_rd_data   (sr_rd_data),
        .hit_rd_data  (hit_rd_data),
        .reg_addr     (reg_addr),
        .gpio_wr      (gpio_wr),
        .sr_wr        (sr_wr),
        .hit_wr       (hit_wr),
        .bus_rd_data  (bus_rd_data)
    );

    gpio_regs u_gpio (
        .bus_clk  (bus_clk),
        .arst_n   (arst_n),
        .wr       (gpio_wr),
        .reg_addr (reg_addr),
        .wr_data  (bus_wr_data),
        .rd_data  (gpio_rd_data),
        .gpio_out (gpio_out)
    );

    // execute stage
    sr_capture u_sr (
        .bus_clk    (bus_clk),
        .arst_n     (arst_n),
        .wr         (sr_wr),
        .reg_addr   (reg_addr),
        .wr_data    (bus_wr_data),
        .sdi        (sdi),
        .sen        (sen),
        .fifo_read  (sr_read),
        .rd_data    (sr_rd_data),
        .fifo_empty (sr_empty),
        .fifo_data  (sr_data)
    );

    hit_timer u_hit (
        .bus_clk    (bus_clk),
        .arst_n     (arst_n),
        .wr         (hit_wr),
        .reg_addr   (reg_addr),
        .wr_data    (bus_wr_data),
        .hit_or     (hit_or),
        .fifo_read  (hit_read),
        .rd_data    (hit_rd_data),
        .fifo_empty (hit_empty),
        .fifo_data  (hit_data)
    );

    // result stage
    rr_arbiter u_arbiter (
        .bus_clk   (bus_clk),
        .arst_n    (arst_n),
        .sr_empty  (sr_empty),
        .sr_data   (sr_data),
        .hit_empty (hit_empty),
        .hit_data  (hit_data),
        .out_read  (out_read),
        .sr_read   (sr_read),
        .hit_read  (hit_read),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: source/rr_arbiter.sv
// round-robin merge of the serial and hit sources into one buffered word
`default_nettype none

module rr_arbiter (
    input  wire              bus_clk,
    input  wire              arst_n,
    input  wire              sr_empty,
    input  pixel_pkg::word_t sr_data,
    input  wire              hit_empty,
    input  pixel_pkg::word_t hit_data,
    input  wire              out_read,
    output logic             sr_read,
    output logic             hit_read,
    output logic             out_valid,
    output pixel_pkg::word_t out_data
);

    logic can_load;
    logic pick_hit;
    logic last_hit;

    // buffer free now, or emptied at this edge
    assign can_load = !out_valid || out_read;

    // with both waiting, take the one not served last
    always_comb begin
        if (!sr_empty && !hit_empty)
            pick_hit = !last_hit;
        else
            pick_hit = !hit_empty;
    end

    assign sr_read  = can_load && !sr_empty && !pick_hit;
    assign hit_read = can_load && !hit_empty && pick_hit;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            last_hit  <= 1'b0;
        end else if (sr_read || hit_read) begin
            out_valid <= 1'b1;
            last_hit  <= hit_read;
        end else if (out_read) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (hit_read)
            out_data <= hit_data;
        else if (sr_read)
            out_data <= sr_data;
    end

endmodule

`default_nettype wire

// File: source/hit_timer.sv
// hit timer measuring hit-OR pulse width and time stamp, queued as tagged words
`default_nettype none
`include "pixel_consts.svh"

module hit_timer (
    input  wire                  bus_clk,
    input  wire                  arst_n,
    input  wire                  wr,
    input  pixel_pkg::reg_addr_t reg_addr,
    input  wire [7:0]            wr_data,
    input  wire                  hit_or,
    input  wire                  fifo_read,
    output logic [7:0]           rd_data,
    output logic                 fifo_empty,
    output pixel_pkg::word_t     fifo_data
);
    import pixel_pkg::*;

    logic       en_q;
    logic [1:0] sync_q;
    logic       hit_d;
    logic       rise;
    logic       fall;
    logic       in_pulse;
    logic [15:0] time_q;
    logic [11:0] width_q;
    logic [15:0] stamp_q;
    logic       push;
    logic       fifo_full;
    logic [7:0] lost_cnt;
    hit_rec_t   rec_in;
    hit_rec_t   rec_out;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n)
            en_q <= 1'b0;
        else if (wr && reg_addr == 4'd0)
            en_q <= wr_data[0];
    end

    // two-stage sync, then one more flop for edge detect
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q   <= 2'b00;
            hit_d    <= 1'b0;
            time_q   <= 16'h0000;
            in_pulse <= 1'b0;
            width_q  <= 12'h000;
        end else begin
            sync_q <= {sync_q[0], hit_or};
            hit_d  <= sync_q[1];
            time_q <= time_q + 1'b1;
            if (rise && en_q) begin
                in_pulse <= 1'b1;
                width_q  <= 12'd1;
            end else if (fall) begin
                in_pulse <= 1'b0;
            end else if (in_pulse && sync_q[1] && width_q != 12'hfff) begin
                width_q <= width_q + 1'b1;
            end
        end
    end

    assign rise = sync_q[1] && !hit_d;
    assign fall = !sync_q[1] && hit_d;

    always_ff @(posedge bus_clk) begin
        if (rise && en_q)
            stamp_q <= time_q;
    end

    // only pulses that started while enabled are recorded
    assign push         = fall && in_pulse;
    assign rec_in.width = width_q;
    assign rec_in.stamp = stamp_q;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n)
            lost_cnt <= 8'h00;
        else if (push && fifo_full && lost_cnt != 8'hff)
            lost_cnt <= lost_cnt + 1'b1;
    end

    word_fifo #(
        .DEPTH     (`PIX_FIFO_DEPTH),
        .payload_t (hit_rec_t)
    ) u_fifo (
        .clk       (bus_clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (rec_in),
        .pop       (fifo_read),
        .pop_data  (rec_out),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    assign fifo_data = {`PIX_HIT_ID, rec_out.width, rec_out.stamp};

    always_comb begin
        case (reg_addr)
            4'd0:    rd_data = {7'b0, en_q};
            4'd1:    rd_data = lost_cnt;
            default: rd_data = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: source/sr_capture.sv
// serial receiver packing the pixel shift-register stream into tagged words
`default_nettype none
`include "pixel_consts.svh"

module sr_capture (
    input  wire                  bus_clk,
    input  wire                  arst_n,
    input  wire                  wr,
    input  pixel_pkg::reg_addr_t reg_addr,
    input  wire [7:0]            wr_data,
    input  wire                  sdi,
    input  wire                  sen,
    input  wire                  fifo_read,
    output logic [7:0]           rd_data,
    output logic                 fifo_empty,
    output pixel_pkg::word_t     fifo_data
);
    import pixel_pkg::*;

    localparam int CW = $clog2(`PIX_SR_BITS + 1);

    logic                    en_q;
    logic [`PIX_SR_BITS-1:0] shift_q;
    logic [CW-1:0]           bit_cnt;
    logic                    push_q;
    logic [7:0]              ovf_cnt;
    logic                    fifo_full;
    word_t                   push_word;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n)
            en_q <= 1'b0;
        else if (wr && reg_addr == 4'd0)
            en_q <= wr_data[0];
    end

    // first bit ends up in the msb
    always_ff @(posedge bus_clk) begin
        if (en_q && sen)
            shift_q <= {shift_q[`PIX_SR_BITS-2:0], sdi};
    end

    // partial words are dropped by clearing the count when sen falls
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
            push_q  <= 1'b0;
        end else begin
            push_q <= 1'b0;
            if (!(en_q && sen)) begin
                bit_cnt <= '0;
            end else if (bit_cnt == CW'(`PIX_SR_BITS - 1)) begin
                bit_cnt <= '0;
                push_q  <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign push_word = {`PIX_SR_ID, shift_q};

    // saturating count of words lost to a full queue
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n)
            ovf_cnt <= 8'h00;
        else if (push_q && fifo_full && ovf_cnt != 8'hff)
            ovf_cnt <= ovf_cnt + 1'b1;
    end

    word_fifo #(
        .DEPTH     (`PIX_FIFO_DEPTH),
        .payload_t (word_t)
    ) u_fifo (
        .clk       (bus_clk),
        .arst_n    (arst_n),
        .push      (push_q),
        .push_data (push_word),
        .pop       (fifo_read),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    always_comb begin
        case (reg_addr)
            4'd0:    rd_data = {7'b0, en_q};
            4'd1:    rd_data = ovf_cnt;
            default: rd_data = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: source/word_fifo.sv
// small synchronous FIFO, circular buffer with a payload type parameter
`default_nettype none
`include "pixel_consts.svh"

module word_fifo #(
    parameter int  DEPTH     = `PIX_FIFO_DEPTH,
    parameter type payload_t = pixel_pkg::word_t
) (
    input  wire      clk,
    input  wire      arst_n,
    input  wire      push,
    input  payload_t push_data,
    input  wire      pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    // push while full is dropped, pop while empty is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty    = count == '0;
    assign full     = count == CW'(DEPTH);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/gpio_regs.sv
// general-purpose output register with bus readback
`default_nettype none

module gpio_regs (
    input  wire                  bus_clk,
    input  wire                  arst_n,
    input  wire                  wr,
    input  pixel_pkg::reg_addr_t reg_addr,
    input  wire [7:0]            wr_data,
    output logic [7:0]           rd_data,
    output logic [7:0]           gpio_out
);

    logic [7:0] out_q;

    // register 0 is the only writable location
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= 8'h00;
        end else if (wr && reg_addr == 4'd0) begin
            out_q <= wr_data;
        end
    end

    assign gpio_out = out_q;

    // readback of register 0, zero elsewhere
    always_comb begin
        if (reg_addr == 4'd0)
            rd_data = out_q;
        else
            rd_data = 8'h00;
    end

endmodule

`default_nettype wire

// File: source/bus_decoder.sv
// register bus decoder, splits writes into block strobes and registers read data
`default_nettype none
`include "pixel_consts.svh"

module bus_decoder (
    input  wire                  bus_clk,
    input  wire                  arst_n,
    input  pixel_pkg::bus_addr_t add,
    input  wire                  bus_rd,
    input  wire                  bus_wr,
    input  wire [7:0]            gpio_rd_data,
    input  wire [7:0]            sr_rd_data,
    input  wire [7:0]            hit_rd_data,
    output pixel_pkg::reg_addr_t reg_addr,
    output logic                 gpio_wr,
    output logic                 sr_wr,
    output logic                 hit_wr,
    output logic [7:0]           bus_rd_data
);
    import pixel_pkg::*;

    localparam bus_addr_t WIN_MASK = 16'hfff0;

    bus_addr_t local_add;
    logic      gpio_sel;
    logic      sr_sel;
    logic      hit_sel;

    assign local_add = add - bus_addr_t'(`PIX_BUS_OFFSET);
    assign reg_addr  = local_add[3:0];

    // window match on the upper twelve bits
    assign gpio_sel = (local_add & WIN_MASK) == bus_addr_t'(`PIX_GPIO_BASE);
    assign sr_sel   = (local_add & WIN_MASK) == bus_addr_t'(`PIX_SR_BASE);
    assign hit_sel  = (local_add & WIN_MASK) == bus_addr_t'(`PIX_HIT_BASE);

    assign gpio_wr = bus_wr && gpio_sel;
    assign sr_wr   = bus_wr && sr_sel;
    assign hit_wr  = bus_wr && hit_sel;

    // read data valid one cycle after the strobe, held until the next read
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_rd_data <= 8'h00;
        end else if (bus_rd) begin
            if (gpio_sel)
                bus_rd_data <= gpio_rd_data;
            else if (sr_sel)
                bus_rd_data <= sr_rd_data;
            else if (hit_sel)
                bus_rd_data <= hit_rd_data;
            else
                bus_rd_data <= 8'h00;
        end
    end

endmodule

`default_nettype wire

// File: source/pixel_pkg.sv
// pixel readout types shared by the bus blocks, data sources and arbiter
`default_nettype none

package pixel_pkg;

    // one word of the merged output stream
    typedef logic [31:0] word_t;

    // full register bus address
    typedef logic [15:0] bus_addr_t;

    // register index inside one 16-register window
    typedef logic [3:0] reg_addr_t;

    // one measured hit, queued before it is formatted
    typedef struct packed {
        logic [11:0] width;
        logic [15:0] stamp;
    } hit_rec_t;

endpackage

`default_nettype wire

// File: source/pixel_consts.svh
// pixel readout constants: bus address map, data identifiers and queue sizes
`ifndef PIXEL_CONSTS_SVH
`define PIXEL_CONSTS_SVH

// external bus addresses start at this offset
`define PIX_BUS_OFFSET 16'h4000

// 16-register windows, relative to the offset
`define PIX_GPIO_BASE 16'h0000
`define PIX_SR_BASE 16'h0100
`define PIX_HIT_BASE 16'h0200

// identifiers carried in word bits 31..28
`define PIX_SR_ID 4'b0010
`define PIX_HIT_ID 4'b0100

// serial payload bits per word
`define PIX_SR_BITS 28
`define PIX_FIFO_DEPTH 4

`endif
